//--- logic/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN = 32;

  // *************************************************************************
  // Encodings shared by decoder and datapath
  // *************************************************************************

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b                       // LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    npc_seq    = 2'd0,
    npc_jal_br = 2'd1,
    npc_jalr   = 2'd2
  } npc_sel_e;

  typedef enum logic [2:0] {
    br_eq     = 3'b000,              // Same as branch funct3
    br_ne     = 3'b001,
    br_always = 3'b010,              // JAL only
    br_lt     = 3'b100,
    br_ge     = 3'b101,
    br_ltu    = 3'b110,
    br_geu    = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {
    wb_alu      = 2'd0,
    wb_pc_plus4 = 2'd1,
    wb_auipc    = 2'd2,
    wb_load     = 2'd3
  } wb_sel_e;

  typedef enum logic [1:0] {
    mem_byte = 2'd0,
    mem_half = 2'd1,
    mem_word = 2'd2
  } mem_size_e;

  typedef struct packed {
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic            alu_b_imm;
    alu_op_e         alu_op;
    npc_sel_e        npc_sel;
    br_cond_e        br_cond;
    logic            reg_wen;
    wb_sel_e         wb_sel;
    logic            mem_ren;
    logic            mem_wen;
    mem_size_e       mem_size;
    logic            mem_unsigned;
    logic            halt;
  } ctrl_t;

endpackage

//--- logic/idu.sv
`timescale 1ns/100ps

module idu (
  input  logic [31:0]        inst,
  output rv_core_pkg::ctrl_t ctrl
);

  import rv_core_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        is_lui, is_auipc, is_jal, is_jalr, is_branch;
  logic        is_load, is_store, is_op_imm, is_op, is_ebreak;
  logic [31:0] u_imm, j_imm, b_imm, i_imm, s_imm;
  alu_op_e     arith_op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // *************************************************************************
  // Opcode groups, only legal funct3/funct7 combinations
  // *************************************************************************

  assign is_lui    = opcode == 7'b01_101_11;
  assign is_auipc  = opcode == 7'b00_101_11;
  assign is_jal    = opcode == 7'b11_011_11;
  assign is_jalr   = opcode == 7'b11_001_11 && funct3 == 3'b000;
  assign is_branch = opcode == 7'b11_000_11 && funct3[2:1] != 2'b01;
  assign is_load   = opcode == 7'b00_000_11 && funct3 != 3'b011 && funct3[2:1] != 2'b11;
  assign is_store  = opcode == 7'b01_000_11 && !funct3[2] && funct3[1:0] != 2'b11;
  assign is_op_imm = opcode == 7'b00_100_11 &&
                     (funct3[1:0] != 2'b01 || funct7 == 7'b00000_00 ||
                      (funct3 == 3'b101 && funct7 == 7'b01000_00));
  assign is_op     = opcode == 7'b01_100_11 &&
                     (funct7 == 7'b00000_00 ||
                      (funct7 == 7'b01000_00 && (funct3 == 3'b000 || funct3 == 3'b101)));
  assign is_ebreak = inst == 32'b0000000_00001_00000_000_00000_11100_11;

  assign u_imm = {inst[31:12], 12'b0};
  assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign i_imm = {{20{inst[31]}}, inst[31:20]};
  assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (is_op && funct7[5]) ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;  // SRAI too
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    ctrl     = '0;                   // Undecoded words do nothing
    ctrl.rs1 = inst[19:15];
    ctrl.rs2 = inst[24:20];
    ctrl.rd  = inst[11:7];
    if (is_lui) begin
      ctrl.imm       = u_imm;
      ctrl.alu_b_imm = 1'b1;
      ctrl.alu_op    = alu_pass_b;
      ctrl.reg_wen   = 1'b1;
    end else if (is_auipc) begin
      ctrl.imm     = u_imm;
      ctrl.reg_wen = 1'b1;
      ctrl.wb_sel  = wb_auipc;
    end else if (is_jal) begin
      ctrl.imm     = j_imm;
      ctrl.npc_sel = npc_jal_br;
      ctrl.br_cond = br_always;
      ctrl.reg_wen = 1'b1;
      ctrl.wb_sel  = wb_pc_plus4;
    end else if (is_jalr) begin
      ctrl.imm       = i_imm;
      ctrl.alu_b_imm = 1'b1;
      ctrl.npc_sel   = npc_jalr;
      ctrl.reg_wen   = 1'b1;
      ctrl.wb_sel    = wb_pc_plus4;
    end else if (is_branch) begin
      ctrl.imm     = b_imm;
      ctrl.npc_sel = npc_jal_br;
      ctrl.br_cond = br_cond_e'(funct3);
    end else if (is_load || is_store) begin
      ctrl.imm          = is_load ? i_imm : s_imm;
      ctrl.alu_b_imm    = 1'b1;      // Address is rs1 + imm
      ctrl.reg_wen      = is_load;
      ctrl.wb_sel       = wb_load;
      ctrl.mem_ren      = is_load;
      ctrl.mem_wen      = is_store;
      ctrl.mem_size     = mem_size_e'(funct3[1:0]);
      ctrl.mem_unsigned = funct3[2];
    end else if (is_op_imm || is_op) begin
      ctrl.imm       = i_imm;
      ctrl.alu_b_imm = is_op_imm;
      ctrl.alu_op    = arith_op;
      ctrl.reg_wen   = 1'b1;
    end else if (is_ebreak) begin
      ctrl.halt = 1'b1;
    end
  end

endmodule

//--- logic/exu_alu.sv
`timescale 1ns/100ps

module exu_alu (
  input  rv_core_pkg::alu_op_e op,
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  output logic [31:0]          result
);

  import rv_core_pkg::*;

  logic [4:0]  shamt;
  logic [31:0] sum;
  logic        lt_signed;
  logic        lt_unsigned;

  assign shamt       = b[4:0];
  assign sum         = a + b;      // Also the memory address and JALR base
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = sum;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {31'b0, lt_signed};
      alu_sltu:   result = {31'b0, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = sum;
    endcase
  end

endmodule

//--- logic/gpr_file.sv
`timescale 1ns/100ps

module gpr_file #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        wen,
  input  logic [4:0]  rd,
  input  logic [31:0] wdata
);

  logic [31:0] regs [NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0 && int'(rd) < NUM_REGS) begin
      regs[rd] <= wdata;
    end
  end

  // x0 and unimplemented registers read zero
  assign rs1_data = (rs1 != 5'd0 && int'(rs1) < NUM_REGS) ? regs[rs1] : '0;
  assign rs2_data = (rs2 != 5'd0 && int'(rs2) < NUM_REGS) ? regs[rs2] : '0;

endmodule

//--- logic/npc_unit.sv
`timescale 1ns/100ps

module npc_unit #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic               clk,
  input  logic               arst_n,
  input  rv_core_pkg::ctrl_t ctrl,
  input  logic [31:0]        rs1_data,
  input  logic [31:0]        rs2_data,
  input  logic [31:0]        alu_sum,
  output logic [31:0]        pc,
  output logic [31:0]        pc_plus4,
  output logic [31:0]        pc_imm,
  output logic               halted
);

  import rv_core_pkg::*;

  logic            br_taken;
  logic [XLEN-1:0] pc_next;

  assign pc_plus4 = pc + 32'd4;
  assign pc_imm   = pc + ctrl.imm;

  always_comb begin
    case (ctrl.br_cond)
      br_eq:     br_taken = rs1_data == rs2_data;
      br_ne:     br_taken = rs1_data != rs2_data;
      br_lt:     br_taken = $signed(rs1_data) < $signed(rs2_data);
      br_ge:     br_taken = $signed(rs1_data) >= $signed(rs2_data);
      br_ltu:    br_taken = rs1_data < rs2_data;
      br_geu:    br_taken = rs1_data >= rs2_data;
      br_always: br_taken = 1'b1;
      default:   br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl.npc_sel)
      npc_jal_br: pc_next = br_taken ? pc_imm : pc_plus4;
      npc_jalr:   pc_next = {alu_sum[31:1], 1'b0};
      default:    pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      halted <= ctrl.halt;
      if (!ctrl.halt) begin
        pc <= pc_next;             // EBREAK keeps its own address
      end
    end
  end

endmodule

//--- logic/lsu.sv
`timescale 1ns/100ps

module lsu (
  input  rv_core_pkg::ctrl_t ctrl,
  input  logic [31:0]        addr,
  input  logic [31:0]        store_data,
  input  logic               enable,
  output logic [31:0]        dmem_addr,
  output logic [31:0]        dmem_wdata,
  output logic [3:0]         dmem_wstrb,
  output logic               dmem_wen,
  output logic               dmem_ren,
  input  logic [31:0]        dmem_rdata,
  output logic [31:0]        load_data
);

  import rv_core_pkg::*;

  logic [1:0]  lane;
  logic [3:0]  strb;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;
  logic        sext;

  assign lane      = addr[1:0];
  assign dmem_addr = {addr[31:2], 2'b00};
  assign dmem_wen  = ctrl.mem_wen & enable;
  assign dmem_ren  = ctrl.mem_ren & enable;

  // *************************************************************************
  // Store lanes
  // *************************************************************************

  always_comb begin
    case (ctrl.mem_size)
      mem_byte: begin
        dmem_wdata = {4{store_data[7:0]}};
        strb       = 4'b0001 << lane;
      end
      mem_half: begin
        dmem_wdata = {2{store_data[15:0]}};
        strb       = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = store_data;
        strb       = 4'b1111;
      end
    endcase
  end

  assign dmem_wstrb = dmem_wen ? strb : 4'b0000;

  // *************************************************************************
  // Load extraction
  // *************************************************************************

  assign rd_byte = dmem_rdata[{lane, 3'b000} +: 8];
  assign rd_half = lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];
  assign sext    = !ctrl.mem_unsigned;

  always_comb begin
    case (ctrl.mem_size)
      mem_byte: load_data = {{24{sext & rd_byte[7]}}, rd_byte};
      mem_half: load_data = {{16{sext & rd_half[15]}}, rd_half};
      default:  load_data = dmem_rdata;
    endcase
  end

endmodule

//--- logic/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0,
  parameter int                           NUM_REGS = 32
) (
  input  logic                         clk,
  input  logic                         arst_n,
  output logic [rv_core_pkg::XLEN-1:0] imem_addr,
  input  logic [31:0]                  imem_rdata,
  output logic [rv_core_pkg::XLEN-1:0] dmem_addr,
  output logic [rv_core_pkg::XLEN-1:0] dmem_wdata,
  output logic [3:0]                   dmem_wstrb,
  output logic                         dmem_wen,
  output logic                         dmem_ren,
  input  logic [rv_core_pkg::XLEN-1:0] dmem_rdata,
  output logic                         halted
);

  import rv_core_pkg::*;

  ctrl_t           ctrl;
  logic [XLEN-1:0] rs1_data, rs2_data;
  logic [XLEN-1:0] alu_b, alu_result;
  logic [XLEN-1:0] pc, pc_plus4, pc_imm;
  logic [XLEN-1:0] load_data, wb_data;
  logic            reg_wen;

  assign imem_addr = pc;
  assign alu_b     = ctrl.alu_b_imm ? ctrl.imm : rs2_data;
  assign reg_wen   = ctrl.reg_wen & ~halted;  // No retire after EBREAK

  always_comb begin
    case (ctrl.wb_sel)
      wb_pc_plus4: wb_data = pc_plus4;
      wb_auipc:    wb_data = pc_imm;
      wb_load:     wb_data = load_data;
      default:     wb_data = alu_result;
    endcase
  end

  idu u_idu (
    .inst (imem_rdata),
    .ctrl (ctrl)
  );

  gpr_file #(
    .NUM_REGS (NUM_REGS)
  ) u_gpr_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (reg_wen),
    .rd       (ctrl.rd),
    .wdata    (wb_data)
  );

  exu_alu u_exu_alu (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  npc_unit #(
    .RESET_PC (RESET_PC)
  ) u_npc_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .alu_sum  (alu_result),
    .pc       (pc),
    .pc_plus4 (pc_plus4),
    .pc_imm   (pc_imm),
    .halted   (halted)
  );

  lsu u_lsu (
    .ctrl       (ctrl),
    .addr       (alu_result),
    .store_data (rs2_data),
    .enable     (~halted),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wen   (dmem_wen),
    .dmem_ren   (dmem_ren),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data)
  );

endmodule

//--- dv/clk_rst_gen.sv
`timescale 1ns/100ps

module clk_rst_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 16
) (
  input  logic rst_req,
  output logic clk,
  output logic arst_n
);

  int cnt = RESET_CYCLES;          // Reset asserted from time zero

  always begin
    clk = 1'b0;
    #(HALF_PERIOD);
    clk = 1'b1;
    #(HALF_PERIOD);
  end

  // A request reloads the counter, reset stays low until it runs out
  always @(posedge clk) begin
    if (rst_req) begin
      cnt <= RESET_CYCLES;
    end else if (cnt != 0) begin
      cnt <= cnt - 1;
    end
  end

  assign arst_n = (cnt == 0);

endmodule

//--- dv/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

  localparam int          OP_LUI      = 'h37;
  localparam int          OP_AUIPC    = 'h17;
  localparam int          OP_JALR     = 'h67;
  localparam int          OP_LOAD     = 'h03;
  localparam int          OP_IMM      = 'h13;
  localparam int          OP_REG      = 'h33;
  localparam logic [31:0] EBREAK      = 32'h0010_0073;
  localparam int          HALT_LIMIT  = 500;
  localparam int          WATCHDOG_NS = 6 * 600 * 4;

  logic        clk, arst_n, rst_req, dmem_clear;
  logic [31:0] imem_addr, imem_rdata;
  logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
  logic [3:0]  dmem_wstrb;
  logic        dmem_wen, dmem_ren, halted;
  logic [31:0] imem [256] = '{default: '0};
  logic [31:0] dmem [256] = '{default: '0};
  logic [31:0] prog [$];
  int          seed      = 88461;
  int          errors    = 0;
  int          checks    = 0;
  int          reads     = 0;
  int          read_base = 0;

  clk_rst_gen #(
    .HALF_PERIOD  (2),
    .RESET_CYCLES (16)
  ) u_clk_rst_gen (
    .rst_req (rst_req),
    .clk     (clk),
    .arst_n  (arst_n)
  );

  rv_core_top #(
    .RESET_PC (32'h0),
    .NUM_REGS (32)
  ) dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wen   (dmem_wen),
    .dmem_ren   (dmem_ren),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  // ************************************************************************
  // Memory models
  // ************************************************************************

  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  function automatic logic [31:0] fill_word(int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a, ~a, a ^ 8'h3c, {a[3:0], a[7:4]}};
  endfunction

  always @(posedge clk) begin
    if (dmem_clear) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else if (arst_n && dmem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) begin
          dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n && dmem_ren) begin
      reads <= reads + 1;              // Load cycles on the data port
    end
  end

  // ************************************************************************
  // Instruction encoders and program building
  // ************************************************************************

  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd, int op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(int off, int rs1, int rs2, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(int imm20, int rd, int op);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] j_type(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic int next_pc();
    return prog.size() * 4;
  endfunction

  task automatic emit(logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic load_const(int rd, logic [31:0] value);
    logic [31:0] hi;
    hi = (value + 32'h800) >> 12;    // Round for the signed low part
    emit(u_type(hi, rd, OP_LUI));
    emit(i_type(value, rd, 0, rd, OP_IMM));
  endtask

  task automatic store_word(int rs2, int idx);
    emit(s_type(idx * 4, rs2, 0, 2));
  endtask

  // ************************************************************************
  // Reference models from the RV32I definitions
  // ************************************************************************

  function automatic logic [31:0] alu_model(int f3, logic alt, logic [31:0] a, logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3: return (a < b) ? 32'd1 : 32'd0;
      4: return a ^ b;
      5: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(int f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ************************************************************************
  // Run and check helpers
  // ************************************************************************

  task automatic run_program(string name);
    int cycles;
    @(posedge clk);
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] <= prog[i];
    end
    rst_req    <= 1'b1;
    dmem_clear <= 1'b1;
    @(posedge clk);
    rst_req    <= 1'b0;
    dmem_clear <= 1'b0;
    @(posedge arst_n);
    read_base = reads;
    cycles    = 0;
    while (!halted && cycles < HALT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("%s: core did not halt within %0d cycles", name, HALT_LIMIT);
      errors++;
    end
    prog.delete();
  endtask

  task automatic check_word(string name, int idx, logic [31:0] expected);
    checks++;
    if (dmem[idx] !== expected) begin
      $display("Fail %s dmem[%0d]: got %h, expected %h", name, idx, dmem[idx], expected);
      errors++;
    end
  endtask

  task automatic check_reads(string name, int expected);
    int got;
    got = reads - read_base;
    checks++;
    if (got != expected) begin
      $display("Fail %s dmem_ren count: got %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  // ************************************************************************
  // Directed tests
  // ************************************************************************

  task automatic test_alu();
    logic [31:0] a, b, imm, sext_imm;
    int          f3s [10] = '{0, 0, 7, 6, 4, 2, 3, 1, 5, 5};
    int          f7s [10] = '{0, 32, 0, 0, 0, 0, 0, 0, 0, 32};
    int          if3s [5] = '{0, 4, 2, 3, 5};
    a        = $random(seed) | 32'h8000_0000;             // Negative, SRA and SLT differ
    b        = ($random(seed) & 32'h7fff_ffff) | 32'h1;   // Positive, nonzero shift
    imm      = $random(seed) | 32'h801;                   // Negative imm, nonzero shift
    sext_imm = {{20{imm[11]}}, imm[11:0]};
    load_const(1, a);
    load_const(2, b);
    for (int k = 0; k < 10; k++) begin
      emit(r_type(f7s[k], 2, 1, f3s[k], 3, OP_REG));
      store_word(3, k);
    end
    for (int k = 0; k < 5; k++) begin
      emit(i_type(k == 4 ? (32'h400 | (imm & 32'd31)) : imm, 1, if3s[k], 3, OP_IMM));
      store_word(3, 10 + k);
    end
    emit(EBREAK);
    run_program("alu");
    for (int k = 0; k < 10; k++) begin
      check_word("alu", k, alu_model(f3s[k], f7s[k] != 0, a, b));
    end
    for (int k = 0; k < 4; k++) begin
      check_word("alu", 10 + k, alu_model(if3s[k], 1'b0, a, sext_imm));
    end
    check_word("alu", 14, alu_model(5, 1'b1, a, imm & 32'd31));   // SRAI
  endtask

  task automatic test_load_store();
    logic [31:0] v;
    logic [31:0] f [8];
    v = ($random(seed) | 32'h8000_8000) & ~32'h0000_0080;   // Both sign cases
    load_const(1, v);
    emit(s_type(0, 1, 0, 0));        // SB, one lane per word
    emit(s_type(5, 1, 0, 0));
    emit(s_type(10, 1, 0, 0));
    emit(s_type(15, 1, 0, 0));
    emit(s_type(16, 1, 0, 1));       // SH low half
    emit(s_type(22, 1, 0, 1));       // SH high half
    emit(s_type(24, 1, 0, 2));
    emit(i_type(24, 0, 0, 3, OP_LOAD));
    emit(i_type(25, 0, 0, 4, OP_LOAD));
    emit(i_type(27, 0, 4, 5, OP_LOAD));   // LBU
    emit(i_type(26, 0, 1, 6, OP_LOAD));
    emit(i_type(24, 0, 5, 7, OP_LOAD));   // LHU
    emit(i_type(24, 0, 2, 8, OP_LOAD));
    for (int r = 3; r <= 8; r++) begin
      store_word(r, r + 5);
    end
    emit(EBREAK);
    run_program("load_store");
    for (int i = 0; i < 8; i++) begin
      f[i] = fill_word(i);
    end
    check_word("load_store", 0, {f[0][31:8], v[7:0]});
    check_word("load_store", 1, {f[1][31:16], v[7:0], f[1][7:0]});
    check_word("load_store", 2, {f[2][31:24], v[7:0], f[2][15:0]});
    check_word("load_store", 3, {v[7:0], f[3][23:0]});
    check_word("load_store", 4, {f[4][31:16], v[15:0]});
    check_word("load_store", 5, {v[15:0], f[5][15:0]});
    check_word("load_store", 6, v);
    check_word("load_store", 7, f[7]);
    check_word("load_store", 8, {{24{v[7]}}, v[7:0]});
    check_word("load_store", 9, {{24{v[15]}}, v[15:8]});
    check_word("load_store", 10, {24'h0, v[31:24]});
    check_word("load_store", 11, {{16{v[31]}}, v[31:16]});
    check_word("load_store", 12, {16'h0, v[15:0]});
    check_word("load_store", 13, v);
    check_reads("load_store", 6);         // One read per load
  endtask

  task automatic test_control();
    logic [31:0] neg, pos, ra, rb;
    int          n, jal_pc, jalr_pc;
    int          bf3 [10]  = '{0, 0, 4, 4, 5, 5, 6, 6, 7, 7};
    int          rs1s [10] = '{5, 4, 4, 5, 5, 4, 5, 4, 4, 5};
    int          rs2s [10] = '{5, 5, 5, 4, 4, 5, 4, 5, 5, 4};
    neg = $random(seed) | 32'h8000_0000;
    pos = $random(seed) & 32'h7fff_ffff;
    n   = 5 + ($random(seed) & 7);
    emit(i_type(n, 0, 0, 1, OP_IMM));
    emit(i_type(0, 0, 0, 2, OP_IMM));
    emit(i_type(0, 0, 0, 3, OP_IMM));
    emit(i_type(1, 3, 0, 3, OP_IMM));    // Loop top
    emit(r_type(0, 3, 2, 0, 2, OP_REG));
    emit(b_type(-8, 3, 1, 1));           // BNE back
    store_word(2, 0);
    load_const(4, neg);
    load_const(5, pos);
    for (int k = 0; k < 10; k++) begin
      emit(b_type(12, rs1s[k], rs2s[k], bf3[k]));
      emit(i_type(1, 0, 0, 6, OP_IMM));  // Not-taken marker
      emit(j_type(8, 0));
      emit(i_type(2, 0, 0, 6, OP_IMM));  // Taken marker
      store_word(6, 1 + k);
    end
    jal_pc = next_pc();
    emit(j_type(8, 7));
    emit(EBREAK);
    store_word(7, 11);
    jalr_pc = next_pc() + 4;
    emit(i_type(jalr_pc + 5, 0, 0, 9, OP_IMM));
    emit(i_type(4, 9, 0, 8, OP_JALR));   // Odd target, bit 0 dropped
    emit(EBREAK);
    emit(u_type(0, 10, OP_AUIPC));       // Landing pc shows bit 0
    store_word(8, 12);
    store_word(10, 13);
    emit(EBREAK);
    run_program("control");
    check_word("control", 0, n * (n + 1) / 2);
    for (int k = 0; k < 10; k++) begin
      ra = (rs1s[k] == 4) ? neg : pos;
      rb = (rs2s[k] == 4) ? neg : pos;
      check_word("control", 1 + k, branch_model(bf3[k], ra, rb) ? 32'd2 : 32'd1);
    end
    check_word("control", 11, jal_pc + 4);
    check_word("control", 12, jalr_pc + 4);
    check_word("control", 13, jalr_pc + 8);
  endtask

  task automatic test_upper_imm();
    logic [31:0] u1, u2, u3;
    int          p2, p3;
    u1 = $random(seed);
    u2 = $random(seed);
    u3 = $random(seed);
    emit(u_type(u1, 1, OP_LUI));
    store_word(1, 0);
    p2 = next_pc();
    emit(u_type(u2, 2, OP_AUIPC));
    store_word(2, 1);
    p3 = next_pc();
    emit(u_type(u3, 3, OP_AUIPC));
    store_word(3, 2);
    emit(EBREAK);
    run_program("upper_imm");
    check_word("upper_imm", 0, {u1[19:0], 12'h000});
    check_word("upper_imm", 1, p2 + {u2[19:0], 12'h000});
    check_word("upper_imm", 2, p3 + {u3[19:0], 12'h000});
  endtask

  task automatic test_zero_halt();
    logic [31:0] v;
    int          ebreak_pc;
    v = $random(seed) | 32'h1;
    emit(i_type(123, 0, 0, 0, OP_IMM));
    emit(u_type(v, 0, OP_LUI));
    store_word(0, 0);
    load_const(1, v);
    ebreak_pc = next_pc();
    emit(EBREAK);
    store_word(1, 1);                    // Must never retire
    run_program("zero_halt");
    repeat (8) @(negedge clk);
    check_word("zero_halt", 0, 32'h0);
    check_word("zero_halt", 1, fill_word(1));
    checks++;
    if (imem_addr !== ebreak_pc) begin
      $display("Fail imem_addr: got %h, expected %h", imem_addr, ebreak_pc);
      errors++;
    end
  endtask

  task automatic test_undecoded();
    logic [31:0] a, b, c;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    load_const(1, a);
    load_const(2, b);
    load_const(3, c);
    store_word(3, 0);
    emit(r_type(1, 2, 1, 0, 3, OP_REG));   // MUL x3, x1, x2
    store_word(3, 1);
    store_word(1, 2);
    emit(EBREAK);
    run_program("undecoded");
    check_word("undecoded", 0, c);
    check_word("undecoded", 1, c);
    check_word("undecoded", 2, a);
    check_reads("undecoded", 0);
  endtask

  initial begin
    rst_req    <= 1'b0;
    dmem_clear <= 1'b0;
    test_alu();
    test_load_store();
    test_control();
    test_upper_imm();
    test_zero_halt();
    test_undecoded();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- rv_core.f
logic/rv_core_pkg.sv
logic/idu.sv
logic/exu_alu.sv
logic/gpr_file.sv
logic/npc_unit.sv
logic/lsu.sv
logic/rv_core_top.sv
dv/clk_rst_gen.sv
dv/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the rv_core testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --timing --top-module tb_rv_core -Mdir obj_dir -f rv_core.f \
  && ./obj_dir/Vtb_rv_core 2>&1 | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
